//--- logic/ctrlPkg.sv
package ctrlPkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Opcodes kept from the MIPS subset
    localparam opcode_t OpR    = 6'b000000;
    localparam opcode_t OpAddi = 6'b001000;
    localparam opcode_t OpBeq  = 6'b000100;
    localparam opcode_t OpBne  = 6'b000101;
    localparam opcode_t OpLw   = 6'b100011;
    localparam opcode_t OpSw   = 6'b101011;

    // Function codes under OpR
    localparam funct_t FunctAdd  = 6'b100000;
    localparam funct_t FunctSub  = 6'b100010;
    localparam funct_t FunctAnd  = 6'b100100;
    localparam funct_t FunctSlt  = 6'b101010;
    localparam funct_t FunctJr   = 6'b001000;
    localparam funct_t FunctMult = 6'b011000;
    localparam funct_t FunctDiv  = 6'b011010;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rFormat_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFormat_t;

    // Same 32-bit word, two field layouts
    typedef union packed {
        rFormat_t rFormat;
        iFormat_t iFormat;
    } instrWord_t;

    typedef enum logic [3:0] {
        ClsAdd, ClsSub, ClsAnd, ClsSlt, ClsAddi, ClsBeq, ClsBne,
        ClsLw, ClsSw, ClsJr, ClsMult, ClsDiv, ClsInvalid
    } instrClass_t;

    typedef enum logic [4:0] {
        StResetInit, StFetch, StPcInc, StDecode,
        StAdd, StSub, StAnd, StSlt, StAddi,
        StWriteRd, StWriteRt,
        StBranchAddr, StBeqCmp, StBneCmp,
        StMemAddr, StMemRead, StLoadWrite, StStore,
        StJr, StMulDiv, StDivide,
        StCauseInvalid, StCauseOverflow, StCauseDivZero, StExceptionVector
    } ctrlState_t;

    // Datapath status bits
    typedef struct packed {
        logic overflow;
        logic zero;
        logic divByZero;
    } aluFlags_t;

    typedef enum logic [2:0] {
        AluLoad = 3'b000,
        AluAdd  = 3'b001,
        AluSub  = 3'b010,
        AluAnd  = 3'b011,
        AluCmp  = 3'b111
    } aluOp_t;

    typedef enum logic [1:0] {PcAlu, PcReg, PcBranch, PcVector} pcSource_t;
    // Stack pointer select is register 29 in the datapath mux
    typedef enum logic [1:0] {DestRt = 2'b00, DestRd = 2'b01, DestSp = 2'b11} regDest_t;
    typedef enum logic [1:0] {WbAlu, WbMem, WbSpInit} memToReg_t;
    typedef enum logic [1:0] {SrcBReg, SrcBFour, SrcBImm} aluSrcB_t;
    typedef enum logic [1:0] {CauseNone, CauseInvalid, CauseOverflow, CauseDivZero} excCause_t;

    // Control word to the datapath
    typedef struct packed {
        logic      memRead;
        logic      memWrite;
        logic      iorD;
        logic      irWrite;
        logic      pcWrite;
        logic      regWrite;
        logic      aluSrcA;
        logic      aluOutWrite;
        logic      hiWrite;
        logic      loWrite;
        logic      divMult;
        logic      epcWrite;
        logic      exceptionTaken;
        regDest_t  regDest;
        memToReg_t memToReg;
        aluSrcB_t  aluSrcB;
        aluOp_t    aluOp;
        pcSource_t pcSource;
        excCause_t cause;
    } ctrlWord_t;

endpackage

//--- logic/instrDecoder.sv
module instrDecoder (
    input  ctrlPkg::instrWord_t  instr,
    output ctrlPkg::instrClass_t instrClass
);
    import ctrlPkg::*;

    // Opcode sits in the same bits for both layouts
    always_comb
    begin
        instrClass = ClsInvalid;
        case (instr.iFormat.opcode)
            OpR:
            begin
                // R-format picks the operation from funct
                case (instr.rFormat.funct)
                    FunctAdd:
                        instrClass = ClsAdd;
                    FunctSub:
                        instrClass = ClsSub;
                    FunctAnd:
                        instrClass = ClsAnd;
                    FunctSlt:
                        instrClass = ClsSlt;
                    FunctJr:
                        instrClass = ClsJr;
                    FunctMult:
                        instrClass = ClsMult;
                    FunctDiv:
                        instrClass = ClsDiv;
                    // Shifts, mfhi, mflo and the rest land here
                    default:
                        instrClass = ClsInvalid;
                endcase
            end
            OpAddi:
                instrClass = ClsAddi;
            OpBeq:
                instrClass = ClsBeq;
            OpBne:
                instrClass = ClsBne;
            OpLw:
                instrClass = ClsLw;
            OpSw:
                instrClass = ClsSw;
            // Unsupported I and J formats
            default:
                instrClass = ClsInvalid;
        endcase
    end

endmodule

//--- logic/stateSequencer.sv
module stateSequencer #(
    parameter int MemWaitCycles   = 2,
    parameter int MulDivCycles    = 32,
    parameter int ExcSettleCycles = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::instrClass_t instrClass,
    input  logic                 overflow,
    input  logic                 divByZero,
    output ctrlPkg::ctrlState_t  state
);
    import ctrlPkg::*;

    // Fixed lengths of the two-cycle write states
    localparam int ResetInitCycles = 2;
    localparam int LoadWriteCycles = 2;

    // Longest stay in any one state sizes the counter
    localparam int FixedMax = (ResetInitCycles > LoadWriteCycles) ?
                              ResetInitCycles : LoadWriteCycles;
    localparam int MemMax   = (MemWaitCycles > FixedMax) ? MemWaitCycles : FixedMax;
    localparam int ExeMax   = (MulDivCycles > ExcSettleCycles) ? MulDivCycles : ExcSettleCycles;
    localparam int MaxWait  = (MemMax > ExeMax) ? MemMax : ExeMax;
    localparam int CntW     = $clog2(MaxWait);

    ctrlState_t     nextState;
    ctrlState_t     decodeTarget;
    instrClass_t    latchedClass;
    logic [CntW-1:0] waitCount;
    int             waitLen;
    logic           lastCycle;

    // Cycles spent in each state
    always_comb
    begin
        case (state)
            StResetInit:
                waitLen = ResetInitCycles;
            StFetch, StMemRead:
                waitLen = MemWaitCycles;
            StLoadWrite:
                waitLen = LoadWriteCycles;
            StMulDiv, StDivide:
                waitLen = MulDivCycles;
            StCauseInvalid, StCauseOverflow, StCauseDivZero:
                waitLen = ExcSettleCycles;
            default:
                waitLen = 1;
        endcase
    end

    // Counts up from zero on entry
    assign lastCycle = (int'(waitCount) == waitLen - 1);

    // First execute state per class
    always_comb
    begin
        case (instrClass)
            ClsAdd:
                decodeTarget = StAdd;
            ClsSub:
                decodeTarget = StSub;
            ClsAnd:
                decodeTarget = StAnd;
            ClsSlt:
                decodeTarget = StSlt;
            ClsAddi:
                decodeTarget = StAddi;
            ClsBeq, ClsBne:
                decodeTarget = StBranchAddr;
            ClsLw, ClsSw:
                decodeTarget = StMemAddr;
            ClsJr:
                decodeTarget = StJr;
            ClsMult:
                decodeTarget = StMulDiv;
            ClsDiv:
                decodeTarget = StDivide;
            default:
                decodeTarget = StCauseInvalid;
        endcase
    end

    always_comb
    begin
        nextState = state;
        // Divider flags a zero divisor in its first cycle only
        if ((state == StDivide) && (waitCount == '0) && divByZero)
            nextState = StCauseDivZero;
        else if (lastCycle)
        begin
            case (state)
                StResetInit:
                    nextState = StFetch;
                StFetch:
                    nextState = StPcInc;
                StPcInc:
                    nextState = StDecode;
                StDecode:
                    nextState = decodeTarget;
                // Overflow replaces the register write
                StAdd, StSub:
                    nextState = overflow ? StCauseOverflow : StWriteRd;
                StAddi:
                    nextState = overflow ? StCauseOverflow : StWriteRt;
                StAnd, StSlt:
                    nextState = StWriteRd;
                StBranchAddr:
                    nextState = (latchedClass == ClsBne) ? StBneCmp : StBeqCmp;
                StMemAddr:
                    nextState = (latchedClass == ClsSw) ? StStore : StMemRead;
                StMemRead:
                    nextState = StLoadWrite;
                StCauseInvalid, StCauseOverflow, StCauseDivZero:
                    nextState = StExceptionVector;
                // Write, compare, store, jr, mult/div and vector all refetch
                default:
                    nextState = StFetch;
            endcase
        end
    end

    // Class held for branch and memory splits after decode
    always_ff @(posedge clk)
    begin
        if (state == StDecode)
            latchedClass <= instrClass;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= StResetInit;
            waitCount <= '0;
        end
        else
        begin
            state <= nextState;
            // Reload on every state change
            if (nextState != state)
                waitCount <= '0;
            else
                waitCount <= waitCount + 1'b1;
        end
    end

    // Counter stays inside the wait of the current state
    waitBound: assert property (@(posedge clk) disable iff (reset)
        int'(waitCount) < waitLen);

    decodeOnce: assert property (@(posedge clk) disable iff (reset)
        (state == StDecode) |=> (state != StDecode));

    // Exceptions only follow decode or execute
    noCauseFromFetch: assert property (@(posedge clk) disable iff (reset)
        (state == StFetch) |=>
            !(state inside {StCauseInvalid, StCauseOverflow, StCauseDivZero}));

endmodule

//--- logic/controlEncoder.sv
module controlEncoder (
    input  ctrlPkg::ctrlState_t state,
    input  logic                zero,
    output ctrlPkg::ctrlWord_t  ctrl
);
    import ctrlPkg::*;

    always_comb
    begin
        // Everything idle unless the state asks
        ctrl = '0;
        case (state)
            StResetInit:
            begin
                // Load initial stack pointer
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = DestSp;
                ctrl.memToReg = WbSpInit;
            end
            StFetch:
            begin
                // Address from PC
                ctrl.memRead = 1'b1;
                ctrl.iorD    = 1'b0;
            end
            StPcInc:
            begin
                // PC + 4
                ctrl.aluSrcB  = SrcBFour;
                ctrl.aluOp    = AluAdd;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PcAlu;
            end
            StDecode:
                ctrl.irWrite = 1'b1;
            StAdd, StSub, StAnd, StSlt:
            begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = SrcBReg;
                ctrl.aluOutWrite = 1'b1;
                case (state)
                    StAdd:
                        ctrl.aluOp = AluAdd;
                    StSub:
                        ctrl.aluOp = AluSub;
                    StAnd:
                        ctrl.aluOp = AluAnd;
                    default:
                        ctrl.aluOp = AluCmp;
                endcase
            end
            // Base plus immediate, shared by addi and address calc
            StAddi, StMemAddr:
            begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluSrcB     = SrcBImm;
                ctrl.aluOp       = AluAdd;
                ctrl.aluOutWrite = 1'b1;
            end
            StWriteRd:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = DestRd;
                ctrl.memToReg = WbAlu;
            end
            StWriteRt:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = DestRt;
                ctrl.memToReg = WbAlu;
            end
            StBranchAddr:
            begin
                // Target from incremented PC
                ctrl.aluSrcB     = SrcBImm;
                ctrl.aluOp       = AluAdd;
                ctrl.aluOutWrite = 1'b1;
            end
            StBeqCmp, StBneCmp:
            begin
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = SrcBReg;
                ctrl.aluOp    = AluSub;
                ctrl.pcSource = PcBranch;
                // Taken only on the matching zero result
                ctrl.pcWrite  = (state == StBeqCmp) ? zero : !zero;
            end
            StMemRead:
            begin
                ctrl.memRead = 1'b1;
                ctrl.iorD    = 1'b1;
            end
            StLoadWrite:
            begin
                ctrl.iorD     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = DestRt;
                ctrl.memToReg = WbMem;
            end
            StStore:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = 1'b1;
            end
            StJr:
            begin
                // rs passes through to PC
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluOp    = AluLoad;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PcReg;
            end
            StMulDiv, StDivide:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.hiWrite = 1'b1;
                ctrl.loWrite = 1'b1;
                ctrl.divMult = (state == StMulDiv);
            end
            StCauseInvalid, StCauseOverflow, StCauseDivZero:
            begin
                // EPC gets PC - 4
                ctrl.epcWrite = 1'b1;
                ctrl.aluSrcB  = SrcBFour;
                ctrl.aluOp    = AluSub;
                case (state)
                    StCauseInvalid:
                        ctrl.cause = CauseInvalid;
                    StCauseOverflow:
                        ctrl.cause = CauseOverflow;
                    default:
                        ctrl.cause = CauseDivZero;
                endcase
            end
            StExceptionVector:
            begin
                ctrl.pcWrite        = 1'b1;
                ctrl.pcSource       = PcVector;
                ctrl.exceptionTaken = 1'b1;
            end
            default:
                ctrl = '0;
        endcase
    end

    // Table-wide checks over every state
    always_comb
    begin
        assert (!(ctrl.memWrite && ctrl.regWrite));
        assert (!ctrl.exceptionTaken || ctrl.pcWrite);
    end

endmodule

//--- logic/controlUnit.sv
module controlUnit #(
    parameter int MemWaitCycles   = 2,
    parameter int MulDivCycles    = 32,
    parameter int ExcSettleCycles = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::instrWord_t instr,
    input  ctrlPkg::aluFlags_t  flags,
    output ctrlPkg::ctrlWord_t  ctrl
);
    import ctrlPkg::*;

    instrClass_t instrClass;
    ctrlState_t  state;

    instrDecoder instrDecoder_inst (
        .instr      (instr),
        .instrClass (instrClass)
    );

    // Waits stand in for memory and divider latency
    stateSequencer #(
        .MemWaitCycles   (MemWaitCycles),
        .MulDivCycles    (MulDivCycles),
        .ExcSettleCycles (ExcSettleCycles)
    ) stateSequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (flags.overflow),
        .divByZero  (flags.divByZero),
        .state      (state)
    );

    controlEncoder controlEncoder_inst (
        .state (state),
        .zero  (flags.zero),
        .ctrl  (ctrl)
    );

endmodule

//--- include/tableRow.svh
`ifndef TABLE_ROW_SVH
`define TABLE_ROW_SVH

// One stimulus row and the response expected over its span
// Span runs from its irWrite pulse up to the next one
typedef struct packed {
    ctrlPkg::opcode_t   opcode;
    ctrlPkg::funct_t    funct;
    ctrlPkg::aluFlags_t flags;
    logic [7:0]         length;
    logic [1:0]         regWrites;
    logic [1:0]         memWrites;
    logic [1:0]         pcWrites;
    logic [1:0]         excTaken;
    ctrlPkg::excCause_t cause;
    // aluOp in the first cycle after decode
    ctrlPkg::aluOp_t    execOp;
    // Write-back fields on every regWrite cycle
    ctrlPkg::regDest_t  wbDest;
    ctrlPkg::memToReg_t wbSrc;
    // Source of any pcWrite that is not PC + 4
    ctrlPkg::pcSource_t jumpSrc;
    logic [5:0]         hiLoCycles;
    logic [5:0]         divMultCycles;
} tableRow_t;

`endif

//--- verif/controlUnitChecker.sv
`include "tableRow.svh"

module controlUnitChecker (
    input  logic               clk,
    input  logic               reset,
    input  ctrlPkg::ctrlWord_t ctrl,
    input  tableRow_t          expRow,
    input  logic               expValid,
    output int                 decodeCount,
    output int                 rowsDone,
    output int                 valueErrors,
    output int                 otherErrors
);
    timeunit 1ns;
    timeprecision 1ps;
    import ctrlPkg::*;

    // Longest legal gap between two decode pulses
    localparam int SpanLimit = 64;

    logic      inSpan = 1'b0;
    logic      initPhase = 1'b0;
    int        initLen;
    int        initSp;
    int        spanLen;
    int        regW;
    int        memW;
    int        pcW;
    int        excT;
    int        hiW;
    int        loW;
    int        divM;
    excCause_t seenCause;

    task automatic compareValue(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            valueErrors++;
            $display("FAIL t=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, expected, actual);
        end
    endtask

    // Per-cycle rules inside one instruction span
    task automatic tallyCycle();
        if (spanLen == 2)
            compareValue("aluOp", int'(expRow.execOp), int'(ctrl.aluOp));
        if (ctrl.regWrite)
        begin
            regW++;
            compareValue("regDest", int'(expRow.wbDest), int'(ctrl.regDest));
            compareValue("memToReg", int'(expRow.wbSrc), int'(ctrl.memToReg));
        end
        // Stores address data memory
        if (ctrl.memWrite)
        begin
            memW++;
            compareValue("iorD", 1, int'(ctrl.iorD));
        end
        if (ctrl.pcWrite)
        begin
            pcW++;
            // Last cycle before the next decode is the PC + 4 write
            if (spanLen == int'(expRow.length))
            begin
                compareValue("pcSource", int'(PcAlu), int'(ctrl.pcSource));
                compareValue("aluSrcB", int'(SrcBFour), int'(ctrl.aluSrcB));
            end
            else
                compareValue("pcSource", int'(expRow.jumpSrc), int'(ctrl.pcSource));
        end
        if (ctrl.exceptionTaken)
            excT++;
        if (ctrl.epcWrite)
        begin
            compareValue("cause", int'(expRow.cause), int'(ctrl.cause));
            seenCause = ctrl.cause;
        end
        // HI and LO always load as a pair
        if (ctrl.hiWrite)
            hiW++;
        if (ctrl.loWrite)
            loW++;
        if (ctrl.divMult)
            divM++;
    endtask

    task automatic closeSpan();
        compareValue("instruction length", int'(expRow.length), spanLen);
        compareValue("regWrite cycles", int'(expRow.regWrites), regW);
        compareValue("memWrite cycles", int'(expRow.memWrites), memW);
        compareValue("pcWrite cycles", int'(expRow.pcWrites), pcW);
        compareValue("exceptionTaken cycles", int'(expRow.excTaken), excT);
        compareValue("cause at epcWrite", int'(expRow.cause), int'(seenCause));
        compareValue("hiWrite cycles", int'(expRow.hiLoCycles), hiW);
        compareValue("loWrite cycles", int'(expRow.hiLoCycles), loW);
        compareValue("divMult cycles", int'(expRow.divMultCycles), divM);
        rowsDone++;
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            // Stack pointer write is the only legal activity
            if (ctrl.memRead | ctrl.memWrite | ctrl.irWrite | ctrl.pcWrite |
                ctrl.epcWrite | ctrl.exceptionTaken | ctrl.hiWrite | ctrl.loWrite)
            begin
                otherErrors++;
                $display("Control strobe active while reset is high at t=%0t", $time);
            end
            initPhase = 1'b1;
            initLen = 0;
            initSp = 0;
            inSpan = 1'b0;
        end
        else
        begin
            // Stack pointer init ends at the first fetch
            if (initPhase)
            begin
                if (ctrl.memRead)
                begin
                    compareValue("reset init cycles", 2, initLen);
                    compareValue("regWrite to stack pointer", 2, initSp);
                    initPhase = 1'b0;
                end
                else
                begin
                    initLen++;
                    if (ctrl.regWrite && ctrl.regDest == DestSp && ctrl.memToReg == WbSpInit)
                        initSp++;
                end
            end
            if (ctrl.irWrite)
            begin
                if (inSpan && expValid)
                    closeSpan();
                decodeCount++;
                inSpan = 1'b1;
                spanLen = 1;
                regW = 0;
                memW = 0;
                pcW = 0;
                excT = 0;
                hiW = 0;
                loW = 0;
                divM = 0;
                seenCause = CauseNone;
            end
            else if (inSpan)
            begin
                spanLen++;
                if (expValid)
                    tallyCycle();
                // Stuck sequencer
                if (spanLen > SpanLimit)
                begin
                    otherErrors++;
                    $display("No decode pulse within %0d cycles of the last one at t=%0t",
                             SpanLimit, $time);
                    inSpan = 1'b0;
                end
            end
        end
    end

endmodule

//--- verif/controlUnitTb.sv
`include "tableRow.svh"

module controlUnitTb;
    timeunit 1ns;
    timeprecision 1ps;
    import ctrlPkg::*;

    localparam int NumRows = 20;
    // Cycles allowed for any single wait
    localparam int WaitLimit = 100;

    logic       clk;
    logic       reset;
    instrWord_t instr;
    aluFlags_t  flags;
    ctrlWord_t  ctrl;
    tableRow_t  expRow;
    logic       expValid;
    int         decodeCount;
    int         rowsDone;
    int         valueErrors;
    int         otherErrors;
    int         timeouts;
    logic [15:0] lfsrState = 16'd42;

    // Fields: opcode, funct, flags {ovf, zero, dbz}, length, regW, memW, pcW, excTaken,
    // then cause, first aluOp, wbDest, wbSrc, jump source, hi/lo cycles, divMult cycles
    tableRow_t rows [NumRows] = '{
        // R-format ALU ops, overflow on and is ignored
        '{OpR, FunctAdd, 3'b000, 8'd6, 2'd1, 2'd0, 2'd1, 2'd0,
          CauseNone, AluAdd, DestRd, WbAlu, PcAlu, 6'd0, 6'd0},
        '{OpR, FunctSub, 3'b000, 8'd6, 2'd1, 2'd0, 2'd1, 2'd0,
          CauseNone, AluSub, DestRd, WbAlu, PcAlu, 6'd0, 6'd0},
        '{OpR, FunctAnd, 3'b100, 8'd6, 2'd1, 2'd0, 2'd1, 2'd0,
          CauseNone, AluAnd, DestRd, WbAlu, PcAlu, 6'd0, 6'd0},
        '{OpR, FunctSlt, 3'b000, 8'd6, 2'd1, 2'd0, 2'd1, 2'd0,
          CauseNone, AluCmp, DestRd, WbAlu, PcAlu, 6'd0, 6'd0},
        '{OpAddi, 6'h00, 3'b000, 8'd6, 2'd1, 2'd0, 2'd1, 2'd0,
          CauseNone, AluAdd, DestRt, WbAlu, PcAlu, 6'd0, 6'd0},
        // Branches, taken ones add a pcWrite
        '{OpBeq, 6'h00, 3'b010, 8'd6, 2'd0, 2'd0, 2'd2, 2'd0,
          CauseNone, AluAdd, DestRt, WbAlu, PcBranch, 6'd0, 6'd0},
        '{OpBeq, 6'h00, 3'b000, 8'd6, 2'd0, 2'd0, 2'd1, 2'd0,
          CauseNone, AluAdd, DestRt, WbAlu, PcBranch, 6'd0, 6'd0},
        '{OpBne, 6'h00, 3'b010, 8'd6, 2'd0, 2'd0, 2'd1, 2'd0,
          CauseNone, AluAdd, DestRt, WbAlu, PcBranch, 6'd0, 6'd0},
        '{OpBne, 6'h00, 3'b000, 8'd6, 2'd0, 2'd0, 2'd2, 2'd0,
          CauseNone, AluAdd, DestRt, WbAlu, PcBranch, 6'd0, 6'd0},
        // Memory and jr
        '{OpLw, 6'h00, 3'b000, 8'd9, 2'd2, 2'd0, 2'd1, 2'd0,
          CauseNone, AluAdd, DestRt, WbMem, PcAlu, 6'd0, 6'd0},
        '{OpSw, 6'h00, 3'b000, 8'd6, 2'd0, 2'd1, 2'd1, 2'd0,
          CauseNone, AluAdd, DestRt, WbAlu, PcAlu, 6'd0, 6'd0},
        '{OpR, FunctJr, 3'b000, 8'd5, 2'd0, 2'd0, 2'd2, 2'd0,
          CauseNone, AluLoad, DestRt, WbAlu, PcReg, 6'd0, 6'd0},
        // Multiply and divide, divByZero ignored for mult
        '{OpR, FunctMult, 3'b000, 8'd36, 2'd0, 2'd0, 2'd1, 2'd0,
          CauseNone, AluLoad, DestRt, WbAlu, PcAlu, 6'd32, 6'd32},
        '{OpR, FunctDiv, 3'b000, 8'd36, 2'd0, 2'd0, 2'd1, 2'd0,
          CauseNone, AluLoad, DestRt, WbAlu, PcAlu, 6'd32, 6'd0},
        '{OpR, FunctMult, 3'b001, 8'd36, 2'd0, 2'd0, 2'd1, 2'd0,
          CauseNone, AluLoad, DestRt, WbAlu, PcAlu, 6'd32, 6'd32},
        // Exceptions, j opcode and sll funct are not kept
        '{6'b000010, 6'h00, 3'b000, 8'd10, 2'd0, 2'd0, 2'd2, 2'd1,
          CauseInvalid, AluSub, DestRt, WbAlu, PcVector, 6'd0, 6'd0},
        '{OpR, 6'b000000, 3'b000, 8'd10, 2'd0, 2'd0, 2'd2, 2'd1,
          CauseInvalid, AluSub, DestRt, WbAlu, PcVector, 6'd0, 6'd0},
        '{OpR, FunctAdd, 3'b100, 8'd11, 2'd0, 2'd0, 2'd2, 2'd1,
          CauseOverflow, AluAdd, DestRd, WbAlu, PcVector, 6'd0, 6'd0},
        '{OpAddi, 6'h00, 3'b100, 8'd11, 2'd0, 2'd0, 2'd2, 2'd1,
          CauseOverflow, AluAdd, DestRt, WbAlu, PcVector, 6'd0, 6'd0},
        '{OpR, FunctDiv, 3'b001, 8'd11, 2'd0, 2'd0, 2'd2, 2'd1,
          CauseDivZero, AluLoad, DestRt, WbAlu, PcVector, 6'd1, 6'd0}
    };

    controlUnit controlUnit_inst (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    controlUnitChecker controlUnitChecker_inst (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .expRow      (expRow),
        .expValid    (expValid),
        .decodeCount (decodeCount),
        .rowsDone    (rowsDone),
        .valueErrors (valueErrors),
        .otherErrors (otherErrors)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic randomBits(input int count, output logic [15:0] value);
        value = '0;
        for (int b = 0; b < count; b++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
    endtask

    // Register fields and immediate are don't-care for control
    task automatic makeInstr(input tableRow_t row, output instrWord_t word);
        logic [15:0] bits;
        word = '0;
        word.iFormat.opcode = row.opcode;
        randomBits(5, bits);
        word.iFormat.rs = bits[4:0];
        randomBits(5, bits);
        word.iFormat.rt = bits[4:0];
        if (row.opcode == OpR)
        begin
            randomBits(10, bits);
            word.rFormat.rd = bits[9:5];
            word.rFormat.shamt = bits[4:0];
            word.rFormat.funct = row.funct;
        end
        else
        begin
            randomBits(16, bits);
            word.iFormat.imm16 = bits;
        end
    endtask

    task automatic waitForDecode(input int target);
        int cycles;
        cycles = 0;
        while (decodeCount < target && cycles < WaitLimit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (decodeCount < target)
        begin
            timeouts++;
            $display("Timeout waiting for decode of row %0d", target - 1);
        end
    endtask

    task automatic waitForRows(input int target);
        int cycles;
        cycles = 0;
        while (rowsDone < target && cycles < WaitLimit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (rowsDone < target)
        begin
            timeouts++;
            $display("Timeout waiting for the checker to finish row %0d", target - 1);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        flags = '0;
        expRow = '0;
        expValid = 1'b0;
        makeInstr(rows[0], instr);
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // Flags for a row follow its decode, next instruction goes up at the same time
        for (int i = 0; i < NumRows; i++)
        begin
            if (timeouts == 0)
            begin
                waitForDecode(i + 1);
                flags = rows[i].flags;
                expRow = rows[i];
                expValid = 1'b1;
                // First row again closes the last span
                if (i + 1 < NumRows)
                    makeInstr(rows[i + 1], instr);
                else
                    makeInstr(rows[0], instr);
            end
        end
        if (timeouts == 0)
            waitForRows(NumRows);
        $display("Error counts: value %0d, other %0d, timeout %0d",
                 valueErrors, otherErrors, timeouts);
        if (valueErrors == 0 && otherErrors == 0 && timeouts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- controlUnit.f
+incdir+include
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/stateSequencer.sv
logic/controlEncoder.sv
logic/controlUnit.sv
verif/controlUnitChecker.sv
verif/controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= controlUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Regression passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
